// ==== common/ahb3_pkg.sv ====
// Shared package: bus widths, bank geometry, address map and AHB-Lite enums
package ahb3_pkg;

  ////////////////////
  // Bus widths
  ////////////////////

  // Address and data bus
  localparam int HADDR_W = 32;
  localparam int HDATA_W = 32;
  // One enable per byte lane
  localparam int BE_W    = HDATA_W / 8;

  ////////////////////
  // Bank geometry
  ////////////////////

  // Words held by one bank
  localparam int BANK_WORDS    = 1024;
  // Word address width inside a bank
  localparam int BANK_ABITS    = 10;
  // Byte offset inside a word
  localparam int BYTE_OFS_BITS = 2;

  ////////////////////
  // Address map
  ////////////////////

  localparam logic [HADDR_W-1:0] BANK0_BASE = 32'h0000_0000;
  localparam logic [HADDR_W-1:0] BANK1_BASE = 32'h0000_1000;
  // 4 KB per bank, so the bank is picked by the bits above this
  localparam int BANK_SPAN_BITS = 12;

  ////////////////////
  // Bus encodings
  ////////////////////

  // Transfer type
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // Transfer size, codes above WORD handled as WORD
  typedef enum logic [2:0] {
    BYTE  = 3'b000,
    HWORD = 3'b001,
    WORD  = 3'b010
  } hsize_e;

  // Slave response
  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_e;

  // Decoder target
  typedef enum logic [1:0] {
    BANK0 = 2'd0,
    BANK1 = 2'd1,
    NONE  = 2'd2
  } slave_sel_e;

  // Default slave FSM
  typedef enum logic [1:0] {
    ERR_IDLE   = 2'd0,
    ERR_FIRST  = 2'd1,
    ERR_SECOND = 2'd2
  } err_state_e;

endpackage

// ==== ram/ram_1r1w.sv ====
// Two-port word RAM: byte-enable write port, registered read port, write forwarding
`timescale 1ns/10ps

module ram_1r1w (
  input  logic                            HCLK,
  input  logic                            HRESETn,
  // Write port
  input  logic [ahb3_pkg::BANK_ABITS-1:0] waddr,
  input  logic                            we,
  input  logic [ahb3_pkg::BE_W-1:0]       be,
  input  logic [ahb3_pkg::HDATA_W-1:0]    din,
  // Read port
  input  logic [ahb3_pkg::BANK_ABITS-1:0] raddr,
  output logic [ahb3_pkg::HDATA_W-1:0]    dout
);
  import ahb3_pkg::*;

  // Storage array
  logic [HDATA_W-1:0] mem [BANK_WORDS];
  // Write and read address the same word on this edge
  logic               fwd_hit;

  assign fwd_hit = we && (waddr == raddr);

  ////////////////////
  // Write port
  ////////////////////

  // Only enabled lanes change
  always_ff @(posedge HCLK) begin
    for (int i = 0; i < BE_W; i++) begin
      if (we && be[i]) begin
        mem[waddr][i*8 +: 8] <= din[i*8 +: 8];
      end
    end
  end

  ////////////////////
  // Read port
  ////////////////////

  // Read address sampled on the edge, array value lands in dout
  // Array is read-first, so lanes written on the same edge come from din
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      dout <= '0;
    end else begin
      for (int i = 0; i < BE_W; i++) begin
        if (fwd_hit && be[i]) begin
          dout[i*8 +: 8] <= din[i*8 +: 8];
        end else begin
          dout[i*8 +: 8] <= mem[raddr][i*8 +: 8];
        end
      end
    end
  end

endmodule

// ==== ram/ahb3_spram.sv ====
// AHB-Lite SRAM bank: byte-enable decode, delayed write, read/write contention stall
`timescale 1ns/10ps

module ahb3_spram (
  input  logic                         HCLK,
  input  logic                         HRESETn,
  // Address phase
  input  logic                         hsel,
  input  logic [ahb3_pkg::HADDR_W-1:0] haddr,
  input  logic                         hwrite,
  input  ahb3_pkg::hsize_e             hsize,
  input  ahb3_pkg::htrans_e            htrans,
  // Data phase
  input  logic [ahb3_pkg::HDATA_W-1:0] hwdata,
  input  logic                         hready,
  output logic [ahb3_pkg::HDATA_W-1:0] hrdata,
  output logic                         hreadyout,
  output ahb3_pkg::hresp_e             hresp
);
  import ahb3_pkg::*;

  ////////////////////
  // Signals
  ////////////////////

  // Accepted active transfer to this bank
  logic                  xfer_ok;
  // Word address of the current address phase
  logic [BANK_ABITS-1:0] ap_word;
  // Pending write, captured at address acceptance
  logic                  we_q;
  logic [BE_W-1:0]       be_q;
  // Word address of the transfer in its data phase
  logic [BANK_ABITS-1:0] addr_q;
  // Read address phase on top of the pending write's word
  logic                  contention;
  logic                  ready;
  // Address fed to the RAM read port
  logic [BANK_ABITS-1:0] rd_word;
  logic [HDATA_W-1:0]    dout;

  ////////////////////
  // Byte enables
  ////////////////////

  // Size mask shifted to the addressed lanes
  function automatic logic [BE_W-1:0] gen_be(
    input hsize_e                   size,
    input logic [BYTE_OFS_BITS-1:0] ofs
  );
    logic [BE_W-1:0] mask;
    case (size)
      BYTE:    mask = 4'b0001;
      HWORD:   mask = 4'b0011;
      // WORD and any wider code
      default: mask = 4'b1111;
    endcase
    return mask << ofs;
  endfunction

  assign xfer_ok = hsel && hready && (htrans == NONSEQ || htrans == SEQ);
  assign ap_word = haddr[BYTE_OFS_BITS +: BANK_ABITS];

  ////////////////////
  // Write pipeline
  ////////////////////

  // Write request lives for one data phase only
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      we_q <= 1'b0;
    end else if (hready) begin
      we_q <= xfer_ok && hwrite;
    end else begin
      we_q <= 1'b0;
    end
  end

  // Lanes and word address of the accepted phase
  always_ff @(posedge HCLK) begin
    if (hready) begin
      be_q   <= gen_be(hsize, haddr[BYTE_OFS_BITS-1:0]);
      addr_q <= ap_word;
    end
  end

  ////////////////////
  // Contention
  ////////////////////

  // Read accepted while the write to that word is still pending
  assign contention = we_q && (addr_q == ap_word) && xfer_ok && !hwrite;

  // Full-word writes are forwarded by the RAM, partial ones cost a cycle
  assign ready = !(contention && !(&be_q));

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      hreadyout <= 1'b1;
    end else begin
      hreadyout <= ready;
    end
  end

  // During a stall re-read the data-phase word, now written
  assign rd_word = hready ? ap_word : addr_q;

  ////////////////////
  // Memory
  ////////////////////

  // Write lands on the edge that closes the data phase
  ram_1r1w ram_i (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .waddr   (addr_q),
    .we      (we_q),
    .be      (be_q),
    .din     (hwdata),
    .raddr   (rd_word),
    .dout    (dout)
  );

  // Response
  assign hrdata = dout;
  // Bank never signals an error
  assign hresp  = OKAY;

endmodule

// ==== src/ahb3_slave_decoder.sv ====
// AHB-Lite address decoder with data-phase response mux and default error slave
`timescale 1ns/10ps

module ahb3_slave_decoder (
  input  logic                         HCLK,
  input  logic                         HRESETn,
  // Master address phase
  input  logic [ahb3_pkg::HADDR_W-1:0] haddr,
  input  ahb3_pkg::htrans_e            htrans,
  input  logic                         hready,
  // Bank 0 response
  input  logic                         bank0_hreadyout,
  input  logic [ahb3_pkg::HDATA_W-1:0] bank0_hrdata,
  input  ahb3_pkg::hresp_e             bank0_hresp,
  // Bank 1 response
  input  logic                         bank1_hreadyout,
  input  logic [ahb3_pkg::HDATA_W-1:0] bank1_hrdata,
  input  ahb3_pkg::hresp_e             bank1_hresp,
  // Selects
  output logic                         bank0_hsel,
  output logic                         bank1_hsel,
  // Response to the master, hreadyout is the bus hready
  output logic                         hreadyout,
  output logic [ahb3_pkg::HDATA_W-1:0] hrdata,
  output ahb3_pkg::hresp_e             hresp
);
  import ahb3_pkg::*;

  // Target of the current address phase
  slave_sel_e addr_sel;
  // Target of the current data phase
  slave_sel_e dsel_q;
  // Default slave
  err_state_e err_q;
  err_state_e err_next;
  // Active transfer into unmapped space
  logic       err_start;

  ////////////////////
  // Address decode
  ////////////////////

  // Bank picked by the bits above the 4 KB span
  always_comb begin
    if (haddr[HADDR_W-1:BANK_SPAN_BITS] == BANK0_BASE[HADDR_W-1:BANK_SPAN_BITS]) begin
      addr_sel = BANK0;
    end else if (haddr[HADDR_W-1:BANK_SPAN_BITS] == BANK1_BASE[HADDR_W-1:BANK_SPAN_BITS]) begin
      addr_sel = BANK1;
    end else begin
      addr_sel = NONE;
    end
  end

  assign bank0_hsel = (addr_sel == BANK0);
  assign bank1_hsel = (addr_sel == BANK1);

  assign err_start = (addr_sel == NONE) && (htrans == NONSEQ || htrans == SEQ);

  // Data-phase select follows accepted address phases
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      dsel_q <= NONE;
    end else if (hready) begin
      dsel_q <= addr_sel;
    end
  end

  ////////////////////
  // Default slave
  ////////////////////

  // Two-cycle ERROR: wait state first, then completion
  always_comb begin
    err_next = err_q;
    case (err_q)
      ERR_FIRST: err_next = ERR_SECOND;
      // Idle and second cycle both sample a new address phase
      default: begin
        if (hready) begin
          err_next = err_start ? ERR_FIRST : ERR_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      err_q <= ERR_IDLE;
    end else begin
      err_q <= err_next;
    end
  end

  ////////////////////
  // Response mux
  ////////////////////

  always_comb begin
    case (dsel_q)
      BANK0: begin
        hreadyout = bank0_hreadyout;
        hrdata    = bank0_hrdata;
        hresp     = bank0_hresp;
      end
      BANK1: begin
        hreadyout = bank1_hreadyout;
        hrdata    = bank1_hrdata;
        hresp     = bank1_hresp;
      end
      default: begin
        // Unmapped, so no read data
        hreadyout = (err_q != ERR_FIRST);
        hrdata    = '0;
        if (err_q == ERR_IDLE) begin
          hresp = OKAY;
        end else begin
          hresp = ERROR;
        end
      end
    endcase
  end

endmodule

// ==== src/ahb3_sram_subsys.sv ====
// Top level: address decoder and two AHB-Lite SRAM banks on one master port
`timescale 1ns/10ps

module ahb3_sram_subsys (
  input  logic                         HCLK,
  input  logic                         HRESETn,
  // Master address phase
  input  logic [ahb3_pkg::HADDR_W-1:0] haddr,
  input  logic                         hwrite,
  input  ahb3_pkg::hsize_e             hsize,
  input  ahb3_pkg::htrans_e            htrans,
  // Master data phase
  input  logic [ahb3_pkg::HDATA_W-1:0] hwdata,
  output logic                         hready,
  output logic [ahb3_pkg::HDATA_W-1:0] hrdata,
  output ahb3_pkg::hresp_e             hresp
);
  import ahb3_pkg::*;

  // Bank selects from the decoder
  logic               bank0_hsel;
  logic               bank1_hsel;
  // Bank responses into the mux
  logic               bank0_hreadyout;
  logic [HDATA_W-1:0] bank0_hrdata;
  hresp_e             bank0_hresp;
  logic               bank1_hreadyout;
  logic [HDATA_W-1:0] bank1_hrdata;
  hresp_e             bank1_hresp;

  // Decoder also drives the bus hready
  ahb3_slave_decoder decoder_i (
    .HCLK            (HCLK),
    .HRESETn         (HRESETn),
    .haddr           (haddr),
    .htrans          (htrans),
    .hready          (hready),
    .bank0_hreadyout (bank0_hreadyout),
    .bank0_hrdata    (bank0_hrdata),
    .bank0_hresp     (bank0_hresp),
    .bank1_hreadyout (bank1_hreadyout),
    .bank1_hrdata    (bank1_hrdata),
    .bank1_hresp     (bank1_hresp),
    .bank0_hsel      (bank0_hsel),
    .bank1_hsel      (bank1_hsel),
    .hreadyout       (hready),
    .hrdata          (hrdata),
    .hresp           (hresp)
  );

  // Bank 0 at 0x0000
  ahb3_spram bank0_i (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .hsel      (bank0_hsel),
    .haddr     (haddr),
    .hwrite    (hwrite),
    .hsize     (hsize),
    .htrans    (htrans),
    .hwdata    (hwdata),
    .hready    (hready),
    .hrdata    (bank0_hrdata),
    .hreadyout (bank0_hreadyout),
    .hresp     (bank0_hresp)
  );

  // Bank 1 at 0x1000
  ahb3_spram bank1_i (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .hsel      (bank1_hsel),
    .haddr     (haddr),
    .hwrite    (hwrite),
    .hsize     (hsize),
    .htrans    (htrans),
    .hwdata    (hwdata),
    .hready    (hready),
    .hrdata    (bank1_hrdata),
    .hreadyout (bank1_hreadyout),
    .hresp     (bank1_hresp)
  );

endmodule

// ==== sim/tb_ahb3_sram_subsys.sv ====
// Testbench with file-driven transfers, random full-word transfers and AHB response checks
`timescale 1ns/10ps

module tb_ahb3_sram_subsys;
  import ahb3_pkg::*;

  ////////////////////
  // Setup
  ////////////////////

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 8;
  // Watchdog budget per transfer
  localparam int CYCLES_PER_XFER = 4;
  // Words per record in the data file
  localparam int REC_FIELDS      = 8;
  localparam int REC_MAX         = 64;
  localparam int RAND_WRITES     = 24;
  // Bits of the ctl column
  localparam int CTL_CHAIN       = 0;
  localparam int CTL_WAIT        = 1;

  // One bus transfer with its expected response
  typedef struct packed {
    logic [7:0]         ctl;
    htrans_e            htrans;
    logic               hwrite;
    hsize_e             hsize;
    logic [HADDR_W-1:0] haddr;
    logic [HDATA_W-1:0] hwdata;
    logic [HDATA_W-1:0] exp_rdata;
    hresp_e             exp_resp;
  } xfer_t;

  logic               HCLK;
  logic               HRESETn;
  logic [HADDR_W-1:0] haddr;
  logic               hwrite;
  hsize_e             hsize;
  htrans_e            htrans;
  logic [HDATA_W-1:0] hwdata;
  logic               hready;
  logic [HDATA_W-1:0] hrdata;
  hresp_e             hresp;

  // Raw words from the data file
  logic [31:0]        file_words [REC_FIELDS*REC_MAX];
  // Reference model of both banks with bank 1 in the upper half
  logic [HDATA_W-1:0] ref_mem [2*BANK_WORDS];
  logic [HADDR_W-1:0] rand_addr [RAND_WRITES];
  xfer_t              xfers [$];
  int                 seed;
  int                 total_xfers;
  int                 cur_idx;

  ahb3_sram_subsys dut_i (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .haddr   (haddr),
    .hwrite  (hwrite),
    .hsize   (hsize),
    .htrans  (htrans),
    .hwdata  (hwdata),
    .hready  (hready),
    .hrdata  (hrdata),
    .hresp   (hresp)
  );

  initial HCLK = 1'b0;
  always #(CLK_PERIOD / 2) HCLK = ~HCLK;

  ////////////////////
  // Address map model
  ////////////////////

  // 4 KB banks picked by the bits above the span
  function automatic slave_sel_e bank_of(input logic [HADDR_W-1:0] a);
    if (a[HADDR_W-1:BANK_SPAN_BITS] == BANK0_BASE[HADDR_W-1:BANK_SPAN_BITS]) begin
      return BANK0;
    end
    if (a[HADDR_W-1:BANK_SPAN_BITS] == BANK1_BASE[HADDR_W-1:BANK_SPAN_BITS]) begin
      return BANK1;
    end
    return NONE;
  endfunction

  function automatic int model_index(input logic [HADDR_W-1:0] a);
    return ((bank_of(a) == BANK1) ? BANK_WORDS : 0) + int'(a[BYTE_OFS_BITS +: BANK_ABITS]);
  endfunction

  ////////////////////
  // Checks
  ////////////////////

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "testbench stopped");
  endtask

  task automatic check_data(input string name, input logic [HDATA_W-1:0] got,
                            input logic [HDATA_W-1:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("mismatch %s: got 0x%08h expected 0x%08h at transfer %0d",
                                  name, got, exp, cur_idx));
    end
  endtask

  task automatic check_resp(input string name, input hresp_e got, input hresp_e exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("mismatch %s: got 0x%0h expected 0x%0h at transfer %0d",
                                  name, got, exp, cur_idx));
    end
  endtask

  // Wait state seen or not during a data phase
  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("mismatch %s: got 0x%0h expected 0x%0h at transfer %0d",
                                  name, got, exp, cur_idx));
    end
  endtask

  task automatic check_xfer(input int idx, input logic saw_wait);
    xfer_t x;
    x = xfers[idx];
    cur_idx = idx;
    check_resp("hresp", hresp, x.exp_resp);
    check_flag("hready_wait", saw_wait, x.ctl[CTL_WAIT]);
    // Read data checked for every active read
    if ((x.htrans == NONSEQ || x.htrans == SEQ) && !x.hwrite) begin
      check_data("hrdata", hrdata, x.exp_rdata);
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic load_records();
    xfer_t x;
    int    b;
    bit    found_end;
    found_end = 1'b0;
    $readmemh("sim/ahb3_testdata.hex", file_words);
    for (int r = 0; r < REC_MAX && !found_end; r++) begin
      b = r * REC_FIELDS;
      // ctl of ff closes the list
      if (file_words[b][7:0] == 8'hff) begin
        found_end = 1'b1;
      end else begin
        x.ctl       = file_words[b][7:0];
        x.htrans    = htrans_e'(file_words[b+1][1:0]);
        x.hwrite    = file_words[b+2][0];
        x.hsize     = hsize_e'(file_words[b+3][2:0]);
        x.haddr     = file_words[b+4];
        x.hwdata    = file_words[b+5];
        x.exp_rdata = file_words[b+6];
        x.exp_resp  = hresp_e'(file_words[b+7][0]);
        xfers.push_back(x);
      end
    end
    if (!found_end || xfers.size() == 0) begin
      stop_with_failure("data file has no end marker or holds no transfers");
    end
  endtask

  // Full-word writes to random mapped words followed by reads of the same words
  task automatic add_random_records();
    xfer_t              x;
    logic [31:0]        r;
    logic [HADDR_W-1:0] a;
    for (int k = 0; k < RAND_WRITES; k++) begin
      r           = $random(seed);
      a           = (r[16] ? BANK1_BASE : BANK0_BASE) |
                    (HADDR_W'(r[BANK_ABITS-1:0]) << BYTE_OFS_BITS);
      x.ctl       = {7'd0, r[20]};
      x.htrans    = NONSEQ;
      x.hwrite    = 1'b1;
      x.hsize     = WORD;
      x.haddr     = a;
      x.hwdata    = $random(seed);
      x.exp_rdata = '0;
      x.exp_resp  = OKAY;
      ref_mem[model_index(a)] = x.hwdata;
      rand_addr[k] = a;
      xfers.push_back(x);
    end
    for (int k = 0; k < RAND_WRITES; k++) begin
      r           = $random(seed);
      x.ctl       = {7'd0, r[20]};
      x.hwrite    = 1'b0;
      x.haddr     = rand_addr[k];
      x.hwdata    = '0;
      x.exp_rdata = ref_mem[model_index(rand_addr[k])];
      xfers.push_back(x);
    end
  endtask

  task automatic drive_addr(input xfer_t x);
    htrans = x.htrans;
    hwrite = x.hwrite;
    hsize  = x.hsize;
    haddr  = x.haddr;
  endtask

  // Address held so an idle after an error stays unmapped
  task automatic drive_idle();
    htrans = IDLE;
    hwrite = 1'b0;
  endtask

  // hready comes from registers and is stable at the falling edge
  task automatic wait_ready(output logic saw_wait);
    saw_wait = 1'b0;
    while (hready !== 1'b1) begin
      saw_wait = 1'b1;
      @(negedge HCLK);
    end
  endtask

  task automatic run_transfers();
    int   i;
    int   n;
    logic chained;
    logic saw_wait;
    n = xfers.size();
    i = 0;
    @(negedge HCLK);
    drive_addr(xfers[0]);
    wait_ready(saw_wait);
    while (i < n) begin
      // Data phase of transfer i
      @(negedge HCLK);
      hwdata  = xfers[i].hwdata;
      chained = xfers[i].ctl[CTL_CHAIN] && (i + 1 < n);
      if (chained) begin
        drive_addr(xfers[i+1]);
      end else begin
        drive_idle();
      end
      wait_ready(saw_wait);
      check_xfer(i, saw_wait);
      i++;
      if (!chained && i < n) begin
        @(negedge HCLK);
        drive_addr(xfers[i]);
        wait_ready(saw_wait);
      end
    end
    @(negedge HCLK);
    drive_idle();
  endtask

  ////////////////////
  // Run control
  ////////////////////

  initial begin : watchdog
    wait (total_xfers > 0);
    #(total_xfers * CYCLES_PER_XFER * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD);
    stop_with_failure("run timed out waiting for hready");
  end

  initial begin : main_flow
    HRESETn     = 1'b0;
    haddr       = '0;
    hwrite      = 1'b0;
    hsize       = WORD;
    htrans      = IDLE;
    hwdata      = '0;
    seed        = 32'h364737f5;
    cur_idx     = 0;
    total_xfers = 0;
    load_records();
    add_random_records();
    total_xfers = xfers.size();
    repeat (RESET_CYCLES) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;
    run_transfers();
    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== sim/ahb3_testdata.hex ====
// Columns: ctl htrans hwrite hsize haddr hwdata exp_rdata exp_resp
// ctl bit0 issues the next record back to back. ctl bit1 expects a wait state. ff ends the list
// Full words in both banks at the same offset
00 2 1 2 00000010 11223344 00000000 0
00 2 1 2 00001010 55667788 00000000 0
00 2 0 2 00000010 00000000 11223344 0
00 2 0 2 00001010 00000000 55667788 0
00 3 1 2 00001ffc cafef00d 00000000 0
00 3 0 2 00001ffc 00000000 cafef00d 0
// Byte lanes of bank 0 word 0x20
00 2 1 2 00000020 a0b0c0d0 00000000 0
00 2 1 0 00000020 5a5a5a11 00000000 0
00 2 1 0 00000021 5a5a225a 00000000 0
00 2 1 0 00000022 5a335a5a 00000000 0
00 2 1 0 00000023 445a5a5a 00000000 0
00 2 0 2 00000020 00000000 44332211 0
// Halfword lanes of bank 1 word 0x1020
00 2 1 2 00001020 01234567 00000000 0
00 2 1 1 00001020 dead89ab 00000000 0
00 2 1 1 00001022 cdefbeef 00000000 0
00 2 0 2 00001020 00000000 cdef89ab 0
// Back-to-back write then read of the same word
01 2 1 2 00000030 13579bdf 00000000 0
00 2 0 2 00000030 00000000 13579bdf 0
01 2 1 0 00000032 5aee5a5a 00000000 0
02 2 0 2 00000030 00000000 13ee9bdf 0
00 2 1 2 00001030 ffffffff 00000000 0
01 2 1 1 00001030 00001234 00000000 0
02 2 0 2 00001030 00000000 ffff1234 0
01 2 1 0 00001031 0000aa00 00000000 0
00 2 0 2 00001010 00000000 55667788 0
00 2 0 2 00001030 00000000 ffffaa34 0
// Unmapped space
02 2 1 2 00002000 deadbeef 00000000 1
02 2 0 2 80000004 00000000 00000000 1
00 2 0 2 00000010 00000000 11223344 0
03 3 0 2 0000fffc 00000000 00000000 1
00 2 0 2 00001010 00000000 55667788 0
00 0 0 2 00003000 00000000 00000000 0
// IDLE and BUSY writes leave memory alone
00 0 1 2 00000010 ffffffff 00000000 0
00 1 1 2 00001010 ffffffff 00000000 0
00 2 0 2 00000010 00000000 11223344 0
00 2 0 2 00001010 00000000 55667788 0
00 2 0 2 00000020 00000000 44332211 0
ff 0 0 0 00000000 00000000 00000000 0

// ==== sources.f ====
common/ahb3_pkg.sv
ram/ram_1r1w.sv
ram/ahb3_spram.sv
src/ahb3_slave_decoder.sv
src/ahb3_sram_subsys.sv
sim/tb_ahb3_sram_subsys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the AHB-Lite SRAM subsystem testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing -j 0 --top-module tb_ahb3_sram_subsys \
  -f sources.f --Mdir obj_dir -o Vtb
status=$?
if [ "$status" -ne 0 ]; then
  echo "compile failed with status $status"
  exit 1
fi

output="$(./obj_dir/Vtb 2>&1)"
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx '=== PASS ==='; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
